//--- common/io_consts.svh
`ifndef IO_CONSTS_SVH
`define IO_CONSTS_SVH

// register bus
`define IO_ADDR_W 32
`define IO_DATA_W 32

// harts double as plic contexts
`define NUM_HARTS 2
// source 0 reserved
`define NUM_IRQS 8

// address map
`define CLINT_BASE 32'h1140_0000
`define CLINT_MASK 32'h0000_FFFF
`define PLIC_BASE  32'h1100_0000
`define PLIC_MASK  32'h003F_FFFF

// clint registers, one word per hart
`define CLINT_MSIP_OFS     32'h0000_0000
`define CLINT_MTIMECMP_OFS 32'h0000_4000
`define CLINT_MTIME_OFS    32'h0000_BFF8

// plic registers
`define PLIC_PENDING_OFS 32'h0000_1000
`define PLIC_ENABLE_OFS  32'h0000_2000
`define PLIC_CLAIM_OFS   32'h0020_0004

`endif

//--- common/io_bus_pkg.sv
`include "io_consts.svh"

package io_bus_pkg;

  typedef logic [`IO_ADDR_W-1:0] io_addr_t;
  typedef logic [`IO_DATA_W-1:0] io_data_t;

  // one request per cycle, no handshake
  typedef struct packed {
    io_addr_t addr;
    logic     write;
    io_data_t wdata;
  } io_req_t;

  typedef struct packed {
    io_data_t rdata;
    logic     err;
  } io_rsp_t;

endpackage

//--- common/irq_pkg.sv
`include "io_consts.svh"

package irq_pkg;

  typedef logic [`NUM_HARTS-1:0] hart_vec_t;
  typedef logic [`NUM_IRQS-1:0] irq_vec_t;

  // id 0 means no interrupt
  typedef logic [$clog2(`NUM_IRQS)-1:0] irq_id_t;

endpackage

//--- source/io_socket.sv
`timescale 1ns/1ps
`include "io_consts.svh"

module io_socket import io_bus_pkg::*; (
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  logic    req_valid_i,
  input  io_req_t req_i,
  output logic    rsp_valid_o,
  output io_rsp_t rsp_o,
  output logic    clint_req_valid_o,
  output logic    plic_req_valid_o,
  output logic    err_req_valid_o,
  output io_req_t dev_req_o,
  input  logic    clint_rsp_valid_i,
  input  io_rsp_t clint_rsp_i,
  input  logic    plic_rsp_valid_i,
  input  io_rsp_t plic_rsp_i,
  input  logic    err_rsp_valid_i,
  input  io_rsp_t err_rsp_i
);

  localparam logic [1:0] SEL_ERR   = 2'd0;
  localparam logic [1:0] SEL_CLINT = 2'd1;
  localparam logic [1:0] SEL_PLIC  = 2'd2;

  logic       clint_hit;
  logic       plic_hit;
  logic [1:0] sel_d;
  logic [1:0] sel_q;

  // base/mask match, clint checked first
  assign clint_hit = (req_i.addr & ~io_addr_t'(`CLINT_MASK)) == io_addr_t'(`CLINT_BASE);
  assign plic_hit  = (req_i.addr & ~io_addr_t'(`PLIC_MASK)) == io_addr_t'(`PLIC_BASE);

  assign sel_d = clint_hit ? SEL_CLINT :
                 plic_hit  ? SEL_PLIC  : SEL_ERR;

  assign clint_req_valid_o = req_valid_i && (sel_d == SEL_CLINT);
  assign plic_req_valid_o  = req_valid_i && (sel_d == SEL_PLIC);
  assign err_req_valid_o   = req_valid_i && (sel_d == SEL_ERR);
  assign dev_req_o         = req_i;

  // which device owns the response in flight
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel_q <= SEL_ERR;
    end else if (req_valid_i) begin
      sel_q <= sel_d;
    end
  end

  always_comb begin
    case (sel_q)
      SEL_CLINT: begin
        rsp_valid_o = clint_rsp_valid_i;
        rsp_o       = clint_rsp_i;
      end
      SEL_PLIC: begin
        rsp_valid_o = plic_rsp_valid_i;
        rsp_o       = plic_rsp_i;
      end
      default: begin
        rsp_valid_o = err_rsp_valid_i;
        rsp_o       = err_rsp_i;
      end
    endcase
  end

endmodule

//--- source/io_error_sink.sv
`timescale 1ns/1ps

module io_error_sink import io_bus_pkg::*; (
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  logic    req_valid_i,
  output logic    rsp_valid_o,
  output io_rsp_t rsp_o
);

  logic    rsp_valid_q;
  io_rsp_t rsp_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;
    end
  end

  // unmapped access, zero data and error
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rsp_q <= '{rdata: '0, err: 1'b1};
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

//--- irq/clint.sv
`timescale 1ns/1ps
`include "io_consts.svh"

module clint import io_bus_pkg::*, irq_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      req_valid_i,
  input  io_req_t   req_i,
  output logic      rsp_valid_o,
  output io_rsp_t   rsp_o,
  output hart_vec_t msip_o,
  output hart_vec_t mtip_o
);

  io_addr_t  ofs;
  logic      wr_en;
  io_data_t  rdata;
  io_data_t  mtime_d;
  io_data_t  mtime_q;
  io_data_t  mtimecmp_d [`NUM_HARTS];
  io_data_t  mtimecmp_q [`NUM_HARTS];
  hart_vec_t msip_d;
  hart_vec_t msip_q;
  hart_vec_t mtip_d;
  hart_vec_t mtip_q;
  logic      rsp_valid_q;
  io_rsp_t   rsp_q;

  //////////////////////////////
  // register decode

  always_comb begin
    ofs        = req_i.addr & io_addr_t'(`CLINT_MASK);
    wr_en      = req_valid_i && req_i.write;
    rdata      = '0;
    msip_d     = msip_q;
    mtimecmp_d = mtimecmp_q;
    // mtime runs on the system clock, writes ignored
    mtime_d    = mtime_q + 1'b1;
    for (int h = 0; h < `NUM_HARTS; h++) begin
      if (ofs == io_addr_t'(`CLINT_MSIP_OFS + 4 * h)) begin
        rdata = io_data_t'(msip_q[h]);
        if (wr_en) begin
          msip_d[h] = req_i.wdata[0];
        end
      end
      if (ofs == io_addr_t'(`CLINT_MTIMECMP_OFS + 4 * h)) begin
        rdata = mtimecmp_q[h];
        if (wr_en) begin
          mtimecmp_d[h] = req_i.wdata;
        end
      end
      // timer compare on next values
      mtip_d[h] = mtime_d >= mtimecmp_d[h];
    end
    if (ofs == io_addr_t'(`CLINT_MTIME_OFS)) begin
      rdata = mtime_q;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '{default: '1};
      msip_q      <= '0;
      mtip_q      <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      mtime_q     <= mtime_d;
      mtimecmp_q  <= mtimecmp_d;
      msip_q      <= msip_d;
      mtip_q      <= mtip_d;
      rsp_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rsp_q <= '{rdata: rdata, err: 1'b0};
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;
  assign msip_o      = msip_q;
  assign mtip_o      = mtip_q;

endmodule

//--- irq/plic.sv
`timescale 1ns/1ps
`include "io_consts.svh"

module plic import io_bus_pkg::*, irq_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      req_valid_i,
  input  io_req_t   req_i,
  output logic      rsp_valid_o,
  output io_rsp_t   rsp_o,
  input  irq_vec_t  irq_src_i,
  output hart_vec_t irq_o
);

  io_addr_t  ofs;
  io_data_t  rdata;
  irq_vec_t  pending;
  irq_id_t   claim_id;
  irq_vec_t  enable_d [`NUM_HARTS];
  irq_vec_t  enable_q [`NUM_HARTS];
  irq_vec_t  claimed_d;
  irq_vec_t  claimed_q;
  hart_vec_t irq_d;
  hart_vec_t irq_q;
  logic      rsp_valid_q;
  io_rsp_t   rsp_q;

  // fixed priority, lowest id wins
  function automatic irq_id_t lowest_id(irq_vec_t v);
    irq_id_t id;
    id = '0;
    for (int i = `NUM_IRQS - 1; i > 0; i--) begin
      if (v[i]) begin
        id = irq_id_t'(i);
      end
    end
    return id;
  endfunction

  //////////////////////////////
  // register decode

  always_comb begin
    ofs       = req_i.addr & io_addr_t'(`PLIC_MASK);
    pending   = irq_src_i & ~irq_vec_t'(1);
    rdata     = '0;
    claim_id  = '0;
    enable_d  = enable_q;
    claimed_d = claimed_q;
    if (ofs == io_addr_t'(`PLIC_PENDING_OFS)) begin
      rdata = io_data_t'(pending);
    end
    for (int c = 0; c < `NUM_HARTS; c++) begin
      if (ofs == io_addr_t'(`PLIC_ENABLE_OFS + 'h80 * c)) begin
        rdata = io_data_t'(enable_q[c]);
        if (req_valid_i && req_i.write) begin
          enable_d[c] = irq_vec_t'(req_i.wdata);
        end
      end
      if (ofs == io_addr_t'(`PLIC_CLAIM_OFS + 'h1000 * c)) begin
        claim_id = lowest_id(pending & enable_q[c] & ~claimed_q);
        if (!req_i.write) begin
          rdata = io_data_t'(claim_id);
          if (req_valid_i && claim_id != '0) begin
            claimed_d[claim_id] = 1'b1;
          end
        end else if (req_valid_i) begin
          // complete
          claimed_d[irq_id_t'(req_i.wdata)] = 1'b0;
        end
      end
    end
    for (int c = 0; c < `NUM_HARTS; c++) begin
      irq_d[c] = |(pending & enable_d[c] & ~claimed_d);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_q    <= '{default: '0};
      claimed_q   <= '0;
      irq_q       <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      enable_q    <= enable_d;
      claimed_q   <= claimed_d;
      irq_q       <= irq_d;
      rsp_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rsp_q <= '{rdata: rdata, err: 1'b0};
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;
  assign irq_o       = irq_q;

endmodule

//--- source/io_subsys.sv
`timescale 1ns/1ps

module io_subsys import io_bus_pkg::*, irq_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      req_valid_i,
  input  io_req_t   req_i,
  output logic      rsp_valid_o,
  output io_rsp_t   rsp_o,
  input  irq_vec_t  irq_src_i,
  output hart_vec_t msip_o,
  output hart_vec_t mtip_o,
  output hart_vec_t irq_o
);

  logic    clint_req_valid;
  logic    plic_req_valid;
  logic    err_req_valid;
  io_req_t dev_req;
  logic    clint_rsp_valid;
  io_rsp_t clint_rsp;
  logic    plic_rsp_valid;
  io_rsp_t plic_rsp;
  logic    err_rsp_valid;
  io_rsp_t err_rsp;

  //////////////////////////////
  // io switch

  io_socket u_socket (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .req_valid_i       (req_valid_i),
    .req_i             (req_i),
    .rsp_valid_o       (rsp_valid_o),
    .rsp_o             (rsp_o),
    .clint_req_valid_o (clint_req_valid),
    .plic_req_valid_o  (plic_req_valid),
    .err_req_valid_o   (err_req_valid),
    .dev_req_o         (dev_req),
    .clint_rsp_valid_i (clint_rsp_valid),
    .clint_rsp_i       (clint_rsp),
    .plic_rsp_valid_i  (plic_rsp_valid),
    .plic_rsp_i        (plic_rsp),
    .err_rsp_valid_i   (err_rsp_valid),
    .err_rsp_i         (err_rsp)
  );

  io_error_sink u_error_sink (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_valid_i (err_req_valid),
    .rsp_valid_o (err_rsp_valid),
    .rsp_o       (err_rsp)
  );

  //////////////////////////////
  // interrupt controllers

  clint u_clint (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_valid_i (clint_req_valid),
    .req_i       (dev_req),
    .rsp_valid_o (clint_rsp_valid),
    .rsp_o       (clint_rsp),
    .msip_o      (msip_o),
    .mtip_o      (mtip_o)
  );

  // device lines map one to one onto plic sources
  plic u_plic (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_valid_i (plic_req_valid),
    .req_i       (dev_req),
    .rsp_valid_o (plic_rsp_valid),
    .rsp_o       (plic_rsp),
    .irq_src_i   (irq_src_i),
    .irq_o       (irq_o)
  );

endmodule

//--- sim/io_subsys_sva.sv
`timescale 1ns/1ps

module io_subsys_sva import irq_pkg::*; (
  input logic      clk_i,
  input logic      arst_n_i,
  input logic      req_valid_i,
  input logic      rsp_valid_o,
  input hart_vec_t msip_o,
  input hart_vec_t mtip_o,
  input hart_vec_t irq_o
);

  // one response per request, one cycle later
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_valid_i |=> rsp_valid_o)
    else $error("response missing one cycle after request");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_valid_o |-> $past(req_valid_i))
    else $error("response without a request");

  assert property (@(posedge clk_i)
    !arst_n_i |-> (!rsp_valid_o && msip_o == '0 && mtip_o == '0 && irq_o == '0))
    else $error("outputs active during reset");

endmodule

bind io_subsys io_subsys_sva u_io_subsys_sva (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .req_valid_i (req_valid_i),
  .rsp_valid_o (rsp_valid_o),
  .msip_o      (msip_o),
  .mtip_o      (mtip_o),
  .irq_o       (irq_o)
);

//--- sim/io_subsys_tb.sv
`timescale 1ns/1ps
`include "io_consts.svh"

module io_subsys_tb import io_bus_pkg::*, irq_pkg::*; ();

  typedef struct packed {
    io_rsp_t rsp;
    logic    chk_data;
  } exp_t;

  localparam int TIMEOUT = 50;

  logic        clk_i = 1'b0;
  logic        arst_n_i;
  logic        req_valid_i;
  io_req_t     req_i;
  logic        rsp_valid_o;
  io_rsp_t     rsp_o;
  irq_vec_t    irq_src_i;
  hart_vec_t   msip_o;
  hart_vec_t   mtip_o;
  hart_vec_t   irq_o;
  logic [31:0] seed = 32'h571941e2;
  exp_t        exp_q [$];
  io_data_t    rd_hist [$];
  logic        req_d = 1'b0;
  int          errors = 0;
  int          tests = 0;
  int          failed = 0;
  // reference state
  hart_vec_t   m_msip;
  io_data_t    m_cmp [`NUM_HARTS];
  irq_vec_t    m_en [`NUM_HARTS];
  irq_vec_t    m_claimed;
  irq_vec_t    m_src;

  always #10 clk_i = ~clk_i;

  io_subsys u_io_subsys (.*);

  //////////////////////////////
  // reference model

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic irq_id_t first_source(irq_vec_t v);
    for (int i = 1; i < `NUM_IRQS; i++) begin
      if (v[i]) begin
        return irq_id_t'(i);
      end
    end
    return '0;
  endfunction

  function automatic hart_vec_t ref_irq();
    hart_vec_t v;
    for (int c = 0; c < `NUM_HARTS; c++) begin
      v[c] = |(m_src & ~irq_vec_t'(1) & m_en[c] & ~m_claimed);
    end
    return v;
  endfunction

  function automatic exp_t ref_access(io_addr_t addr, logic wr, io_data_t wdata);
    exp_t     e;
    io_addr_t ofs;
    irq_id_t  id;
    e = '0;
    e.chk_data = 1'b1;
    if ((addr & ~`CLINT_MASK) == `CLINT_BASE) begin
      ofs = addr & `CLINT_MASK;
      for (int h = 0; h < `NUM_HARTS; h++) begin
        if (ofs == `CLINT_MSIP_OFS + 4 * h) begin
          e.rsp.rdata = io_data_t'(m_msip[h]);
          m_msip[h] = wr ? wdata[0] : m_msip[h];
        end
        if (ofs == `CLINT_MTIMECMP_OFS + 4 * h) begin
          e.rsp.rdata = m_cmp[h];
          m_cmp[h] = wr ? wdata : m_cmp[h];
        end
      end
      // free-running, value not modelled
      e.chk_data = (ofs != `CLINT_MTIME_OFS);
    end else if ((addr & ~`PLIC_MASK) == `PLIC_BASE) begin
      ofs = addr & `PLIC_MASK;
      if (ofs == `PLIC_PENDING_OFS) begin
        e.rsp.rdata = io_data_t'(m_src & ~irq_vec_t'(1));
      end
      for (int c = 0; c < `NUM_HARTS; c++) begin
        if (ofs == `PLIC_ENABLE_OFS + 'h80 * c) begin
          e.rsp.rdata = io_data_t'(m_en[c]);
          m_en[c] = wr ? irq_vec_t'(wdata) : m_en[c];
        end
        if (ofs == `PLIC_CLAIM_OFS + 'h1000 * c && wr) begin
          m_claimed[irq_id_t'(wdata)] = 1'b0;
        end else if (ofs == `PLIC_CLAIM_OFS + 'h1000 * c) begin
          id = first_source(m_src & m_en[c] & ~m_claimed);
          e.rsp.rdata = io_data_t'(id);
          m_claimed[id] = m_claimed[id] | (id != 0);
        end
      end
    end else begin
      e.rsp.err = 1'b1;
    end
    e.chk_data = e.chk_data && (!wr || e.rsp.err);
    return e;
  endfunction

  //////////////////////////////
  // checking

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  always @(negedge clk_i) begin
    exp_t e;
    if (arst_n_i) begin
      check_value("rsp_valid_o", rsp_valid_o, req_d);
      if (rsp_valid_o === 1'b1 && exp_q.size() == 0) begin
        $display("response arrived with no request outstanding");
        errors++;
      end else if (rsp_valid_o === 1'b1) begin
        e = exp_q.pop_front();
        rd_hist.push_back(rsp_o.rdata);
        check_value("rsp_o.err", rsp_o.err, e.rsp.err);
        if (e.chk_data) begin
          check_value("rsp_o.rdata", rsp_o.rdata, e.rsp.rdata);
        end
      end
      req_d = req_valid_i;
    end
  end

  //////////////////////////////
  // stimulus

  task automatic send_req(io_addr_t addr, logic wr, io_data_t wdata);
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_i       <= '{addr: addr, write: wr, wdata: wdata};
    exp_q.push_back(ref_access(addr, wr, wdata));
  endtask

  task automatic finish_burst();
    int waited;
    waited = 0;
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    while (exp_q.size() != 0 && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: responses still outstanding after %0d cycles", waited);
      $display("TEST FAIL");
      $finish;
    end
  endtask

  task automatic set_sources(irq_vec_t v);
    @(posedge clk_i);
    irq_src_i <= v;
    m_src = v;
  endtask

  task automatic claim(int c);
    send_req(`PLIC_BASE + `PLIC_CLAIM_OFS + 'h1000 * c, 1'b0, '0);
  endtask

  task automatic end_test(string name, int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("%s: ok", name);
    end else begin
      failed++;
      $display("%s: failed", name);
    end
  endtask

  initial begin
    int          base;
    io_addr_t    addr;
    logic [31:0] rnd;
    hart_vec_t   exp_mtip;
    m_msip      = '0;
    m_cmp       = '{default: '1};
    m_en        = '{default: '0};
    m_claimed   = '0;
    m_src       = '0;
    arst_n_i    = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    irq_src_i   = '0;
    repeat (16) @(posedge clk_i);
    arst_n_i <= 1'b1;

    base = errors;
    @(negedge clk_i);
    check_value("rsp_valid_o", rsp_valid_o, 1'b0);
    check_value("msip_o", msip_o, '0);
    check_value("mtip_o", mtip_o, '0);
    check_value("irq_o", irq_o, '0);
    end_test("reset state", base);

    // both windows sit in the 0x1xxxxxxx range
    base = errors;
    for (int i = 0; i < 12; i++) begin
      addr = next_rand();
      rnd  = next_rand();
      addr[31] = addr[31] | (addr[31:28] == 4'h1);
      send_req(addr, rnd[0], rnd);
    end
    finish_burst();
    end_test("unmapped access", base);

    base = errors;
    for (int v = 1; v >= 0; v--) begin
      for (int h = 0; h < `NUM_HARTS; h++) begin
        rnd = next_rand();
        rnd[0] = v[0];
        send_req(`CLINT_BASE + `CLINT_MSIP_OFS + 4 * h, 1'b1, rnd);
        send_req(`CLINT_BASE + `CLINT_MSIP_OFS + 4 * h, 1'b0, '0);
        finish_burst();
        check_value("msip_o", msip_o, m_msip);
      end
    end
    end_test("msip", base);

    base = errors;
    for (int h = 0; h < `NUM_HARTS; h++) begin
      for (int v = 0; v < 2; v++) begin
        send_req(`CLINT_BASE + `CLINT_MTIMECMP_OFS + 4 * h, 1'b1, v ? '1 : '0);
        send_req(`CLINT_BASE + `CLINT_MTIMECMP_OFS + 4 * h, 1'b0, '0);
        finish_burst();
        // mtime stays far below all ones
        for (int k = 0; k < `NUM_HARTS; k++) begin
          exp_mtip[k] = (m_cmp[k] == '0);
        end
        check_value("mtip_o", mtip_o, exp_mtip);
      end
    end
    rd_hist.delete();
    send_req(`CLINT_BASE + `CLINT_MTIME_OFS, 1'b0, '0);
    send_req(`CLINT_BASE + `CLINT_MTIME_OFS, 1'b0, '0);
    finish_burst();
    check_value("mtime increasing", rd_hist[1] > rd_hist[0], 1'b1);
    end_test("timer", base);

    base = errors;
    for (int r = 0; r < 8; r++) begin
      rnd = next_rand();
      set_sources(rnd[`NUM_IRQS-1:0]);
      for (int c = 0; c < `NUM_HARTS; c++) begin
        send_req(`PLIC_BASE + `PLIC_ENABLE_OFS + 'h80 * c, 1'b1, next_rand());
        send_req(`PLIC_BASE + `PLIC_ENABLE_OFS + 'h80 * c, 1'b0, '0);
      end
      send_req(`PLIC_BASE + `PLIC_PENDING_OFS, 1'b0, '0);
      finish_burst();
      check_value("irq_o", irq_o, ref_irq());
    end
    end_test("pending and enable", base);

    base = errors;
    set_sources(8'b1010_0111);
    send_req(`PLIC_BASE + `PLIC_ENABLE_OFS, 1'b1, 32'hFE);
    send_req(`PLIC_BASE + `PLIC_ENABLE_OFS + 'h80, 1'b1, 32'h24);
    claim(0);
    claim(0);
    claim(1);
    claim(1);
    finish_burst();
    check_value("irq_o", irq_o, ref_irq());
    claim(0);
    claim(0);
    finish_burst();
    check_value("irq_o", irq_o, ref_irq());
    // complete source 2 through context 1
    send_req(`PLIC_BASE + `PLIC_CLAIM_OFS + 'h1000, 1'b1, 32'd2);
    finish_burst();
    check_value("irq_o", irq_o, ref_irq());
    claim(1);
    claim(0);
    finish_burst();
    check_value("irq_o", irq_o, ref_irq());
    end_test("claim and complete", base);

    $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+common
common/io_bus_pkg.sv
common/irq_pkg.sv
source/io_socket.sv
source/io_error_sink.sv
irq/clint.sv
irq/plic.sv
source/io_subsys.sv
sim/io_subsys_sva.sv
sim/io_subsys_tb.sv
